// File: rtl/memPkg.sv
`default_nettype none

package memPkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  len_t;
    typedef logic [2:0]  stage_t;

    // who drives the RAM port
    typedef enum logic [1:0] {
        ownIdle  = 2'b00,
        ownData  = 2'b01,
        ownFetch = 2'b10
    } owner_e;

    typedef enum logic [1:0] {
        sIdle,
        sData,
        sFetch
    } ctrlState_e;

    // one single-byte RAM access
    typedef struct packed {
        logic  write;
        addr_t addr;
        byte_t wdata;
    } memReq_t;

    // load or store from the data side
    typedef struct packed {
        logic  isStore;
        len_t  len;
        addr_t addr;
        word_t wdata;
    } dataReq_t;

    localparam int    ramAddrBits = 10;
    localparam addr_t pcStep      = 32'd4;
    localparam addr_t resetPc     = 32'd0;
    // an instruction fetch is always a full word
    localparam len_t  wordBytes   = 3'd4;

endpackage

`default_nettype wire

// File: rtl/fetchPort.sv
`timescale 1ns/1ps
`default_nettype none

module fetchPort import memPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  hold,
    input  logic  redirect,
    input  addr_t redirectPc,
    input  logic  fetchDone,
    input  word_t fetchInst,
    output logic  fetchEn,
    output addr_t fetchAddr,
    output logic  fetchValid,
    output addr_t fetchedPc,
    output word_t fetchedInst
);

    addr_t pc;
    logic  running;
    logic  pendValid;
    addr_t pendPc;

    // running goes high one cycle after reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= resetPc;
            running   <= 1'b0;
            pendValid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (fetchDone) begin
                // a redirect in the done cycle itself wins over an older one
                if (redirect) begin
                    pc <= redirectPc;
                end else if (pendValid) begin
                    pc <= pendPc;
                end else begin
                    pc <= pc + pcStep;
                end
                pendValid <= 1'b0;
            end else if (redirect) begin
                pendValid <= 1'b1;
            end
        end
    end

    // target kept until the fetch in flight is done
    always_ff @(posedge clk) begin
        if (redirect && !fetchDone) begin
            pendPc <= redirectPc;
        end
    end

    assign fetchEn     = running && !hold;
    assign fetchAddr   = pc;
    assign fetchValid  = fetchDone;
    assign fetchedPc   = pc;
    assign fetchedInst = fetchInst;

    // the controller only completes fetches that were requested
    doneNeedsEnable: assert property (
        @(posedge clk) disable iff (rst)
        fetchDone |-> fetchEn
    ) else $error("fetchDone while fetchEn is low");

endmodule

`default_nettype wire

// File: rtl/memCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrl import memPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     fetchEn,
    input  addr_t    fetchAddr,
    input  logic     dataEn,
    input  dataReq_t dataReq,
    input  byte_t    ramRdata,
    output memReq_t  memReq,
    output logic     fetchDone,
    output word_t    fetchInst,
    output logic     dataDone,
    output word_t    dataRdata,
    output owner_e   owner
);

    ctrlState_e state;
    stage_t     stage;
    dataReq_t   curReq;
    dataReq_t   startReq;
    word_t      asmReg;
    word_t      assembled;
    word_t      loadWord;
    logic       starting;
    logic       busy;
    logic       lastStage;

    // data has priority, but only when choosing from idle
    assign starting = (state == sIdle) && !hold && (dataEn || fetchEn);
    assign busy     = (state != sIdle);
    assign lastStage = (stage == curReq.len);

    always_comb begin
        if (dataEn) begin
            startReq = dataReq;
        end else begin
            startReq = '{isStore: 1'b0, len: wordBytes, addr: fetchAddr, wdata: '0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sIdle;
            stage <= '0;
        end else if (!hold) begin
            case (state)
                sIdle: begin
                    if (starting) begin
                        state <= dataEn ? sData : sFetch;
                        stage <= 3'd1;
                    end
                end
                default: begin
                    if (lastStage) begin
                        state <= sIdle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    // request and assembly register are payload
    always_ff @(posedge clk) begin
        if (!hold) begin
            if (starting) begin
                curReq <= startReq;
                asmReg <= '0;
            end else if (busy) begin
                asmReg <= assembled;
            end
        end
    end

    // byte i lands in the top lane and moves down, so the last byte completes the word
    assign assembled = {ramRdata, asmReg[31:8]};

    always_comb begin
        case (curReq.len)
            3'd1:    loadWord = {24'b0, assembled[31:24]};
            3'd2:    loadWord = {16'b0, assembled[31:16]};
            default: loadWord = assembled;
        endcase
    end

    always_comb begin
        memReq = '{write: 1'b0, addr: '0, wdata: '0};
        if (starting) begin
            memReq.write = startReq.isStore;
            memReq.addr  = startReq.addr;
            memReq.wdata = startReq.wdata[7:0];
        end else if (busy && !lastStage) begin
            memReq.write = curReq.isStore;
            memReq.addr  = curReq.addr + addr_t'(stage);
            memReq.wdata = byte_t'(curReq.wdata >> {stage, 3'b000});
        end
    end

    // done is an enabled-cycle pulse, a frozen done cycle repeats after the freeze
    assign dataDone  = (state == sData) && lastStage && !hold;
    assign fetchDone = (state == sFetch) && lastStage && !hold;
    assign dataRdata = curReq.isStore ? '0 : loadWord;
    assign fetchInst = assembled;

    always_comb begin
        case (state)
            sData:   owner = ownData;
            sFetch:  owner = ownFetch;
            default: begin
                if (starting) begin
                    owner = dataEn ? ownData : ownFetch;
                end else begin
                    owner = ownIdle;
                end
            end
        endcase
    end

    legalLength: assert property (
        @(posedge clk) disable iff (rst)
        busy |-> (curReq.len inside {3'd1, 3'd2, 3'd4})
    ) else $error("illegal access length %0d", curReq.len);

    singleDone: assert property (
        @(posedge clk) disable iff (rst)
        !(fetchDone && dataDone)
    ) else $error("fetch and data done together");

    // ownership is fixed from the start cycle to done
    stableOwner: assert property (
        @(posedge clk) disable iff (rst)
        busy |-> (owner == $past(owner))
    ) else $error("owner changed inside a transfer");

endmodule

`default_nettype wire

// File: rtl/byteRam.sv
`timescale 1ns/1ps
`default_nettype none

module byteRam import memPkg::*; (
    input  logic    clk,
    input  logic    hold,
    input  memReq_t memReq,
    output byte_t   rdata
);

    localparam int depth = 2 ** ramAddrBits;

    byte_t                  mem [depth];
    logic [ramAddrBits-1:0] idx;

    // upper address bits are ignored
    assign idx = memReq.addr[ramAddrBits-1:0];

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // a frozen cycle neither writes nor moves the read data
    always_ff @(posedge clk) begin
        if (!hold) begin
            if (memReq.write) begin
                mem[idx] <= memReq.wdata;
            end
            rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// File: rtl/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem import memPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,
    input  logic     ioBufferFull,
    input  logic     redirect,
    input  addr_t    redirectPc,
    input  logic     dataEn,
    input  dataReq_t dataReq,
    output logic     dataDone,
    output word_t    dataRdata,
    output logic     fetchValid,
    output addr_t    fetchedPc,
    output word_t    fetchedInst,
    output owner_e   owner
);

    logic    hold;
    logic    fetchEn;
    addr_t   fetchAddr;
    logic    fetchDone;
    word_t   fetchInst;
    memReq_t memReq;
    byte_t   ramRdata;

    // one freeze for everything
    assign hold = !rdy || ioBufferFull;

    fetchPort fetchPortInst (
        .clk        (clk),
        .rst        (rst),
        .hold       (hold),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .fetchValid (fetchValid),
        .fetchedPc  (fetchedPc),
        .fetchedInst(fetchedInst)
    );

    memCtrl memCtrlInst (
        .clk       (clk),
        .rst       (rst),
        .hold      (hold),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .dataEn    (dataEn),
        .dataReq   (dataReq),
        .ramRdata  (ramRdata),
        .memReq    (memReq),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .owner     (owner)
    );

    byteRam byteRamInst (
        .clk   (clk),
        .hold  (hold),
        .memReq(memReq),
        .rdata (ramRdata)
    );

endmodule

`default_nettype wire

// File: include/tbTypes.svh
`ifndef TB_TYPES_SVH
`define TB_TYPES_SVH

// run length and watchdog
localparam int numOps        = 400;
localparam int timeoutCycles = 12 * numOps * 6;

// data requests stay inside this many bytes
localparam int windowBytes = 256;

// one data request as issued, with the value the model expects back
typedef struct packed {
    logic          isStore;
    memPkg::len_t  len;
    memPkg::addr_t addr;
    memPkg::word_t wdata;
    memPkg::word_t expected;
} tbTxn_t;

`endif

// File: verification/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb import memPkg::*; ();

    `include "tbTypes.svh"

    localparam int ramBytes = 2 ** ramAddrBits;

    logic     clk = 1'b0;
    logic     rst;
    logic     rdy;
    logic     ioBufferFull;
    logic     redirect;
    addr_t    redirectPc;
    logic     dataEn;
    dataReq_t dataReq;
    logic     dataDone;
    word_t    dataRdata;
    logic     fetchValid;
    addr_t    fetchedPc;
    word_t    fetchedInst;
    owner_e   owner;

    // reference model state
    byte_t  modelMem [ramBytes];
    addr_t  modelPc;
    logic   pendValid;
    addr_t  pendPc;
    tbTxn_t curTxn;
    owner_e prevOwner;
    logic   prevDone;
    int     issueCount;
    int     doneCount;
    int     fetchCount;
    int     cycleCount = 0;

    memSubsystem DUT (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .ioBufferFull(ioBufferFull),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .dataEn      (dataEn),
        .dataReq     (dataReq),
        .dataDone    (dataDone),
        .dataRdata   (dataRdata),
        .fetchValid  (fetchValid),
        .fetchedPc   (fetchedPc),
        .fetchedInst (fetchedInst),
        .owner       (owner)
    );

    always #5 clk = ~clk;

    task automatic stopRun(string why);
        $display("Regression failed");
        $fatal(1, "%s", why);
    endtask

    task automatic checkWord(string testName, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h actual %h", testName, expected, actual);
            stopRun("word compare failed");
        end
    endtask

    task automatic checkAddr(string testName, addr_t expected, addr_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h actual %h", testName, expected, actual);
            stopRun("address compare failed");
        end
    endtask

    task automatic checkOwner(string testName, owner_e expected, owner_e actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %s actual %b", testName, expected.name(), actual);
            stopRun("owner compare failed");
        end
    endtask

    function automatic logic [ramAddrBits-1:0] ramIndex(addr_t addr);
        return addr[ramAddrBits-1:0];
    endfunction

    // little-endian, upper bytes stay zero
    function automatic word_t readModel(addr_t addr, int bytes);
        word_t w;
        w = '0;
        for (int i = 0; i < bytes; i++) begin
            w[8*i +: 8] = modelMem[ramIndex(addr + addr_t'(i))];
        end
        return w;
    endfunction

    task automatic writeModel(tbTxn_t txn);
        for (int i = 0; i < int'(txn.len); i++) begin
            modelMem[ramIndex(txn.addr + addr_t'(i))] = txn.wdata[8*i +: 8];
        end
    endtask

    // outputs are settled at the falling edge
    task automatic sampleCycle();
        @(negedge clk);
        if (dataDone && fetchValid) begin
            stopRun("dataDone and fetchValid were high in the same cycle");
        end
        if (prevOwner != ownIdle && !prevDone) begin
            checkOwner("ownerHeld", prevOwner, owner);
        end else if (owner != ownIdle && dataEn) begin
            checkOwner("dataPriority", ownData, owner);
        end
        if (dataDone) begin
            checkOwner("dataDoneOwner", ownData, owner);
            if (doneCount >= issueCount) begin
                stopRun("dataDone without an outstanding data request");
            end
            if (curTxn.isStore) begin
                writeModel(curTxn);
            end else begin
                checkWord($sformatf("load %0d at %h", doneCount, curTxn.addr),
                          curTxn.expected, dataRdata);
            end
            doneCount++;
        end
        if (fetchValid) begin
            checkOwner("fetchOwner", ownFetch, owner);
            checkAddr("fetchedPc", modelPc, fetchedPc);
            checkWord($sformatf("fetch at %h", modelPc), readModel(modelPc, 4), fetchedInst);
            fetchCount++;
            // a redirect in the done cycle itself beats an older pending one
            if (redirect) begin
                modelPc = redirectPc;
            end else if (pendValid) begin
                modelPc = pendPc;
            end else begin
                modelPc = modelPc + pcStep;
            end
            pendValid = 1'b0;
        end else if (redirect) begin
            pendValid = 1'b1;
            pendPc    = redirectPc;
        end
        prevOwner = owner;
        prevDone  = dataDone || fetchValid;
    endtask

    task automatic driveCycle();
        int freeze;
        int target;
        sampleCycle();
        @(posedge clk);
        freeze = $urandom_range(0, 9);
        target = $urandom_range(0, 255);
        rdy          <= (freeze != 0);
        ioBufferFull <= (freeze == 1);
        redirect     <= ($urandom_range(0, 15) == 0);
        redirectPc   <= addr_t'(target * 4);
    endtask

    task automatic issueRequest(logic doStore, len_t len, addr_t addr, word_t wdata);
        int startDone;
        curTxn.isStore  = doStore;
        curTxn.len      = len;
        curTxn.addr     = addr;
        curTxn.wdata    = wdata;
        curTxn.expected = doStore ? '0 : readModel(addr, int'(len));
        dataEn  <= 1'b1;
        dataReq <= '{isStore: doStore, len: len, addr: addr, wdata: wdata};
        issueCount++;
        startDone = doneCount;
        do begin
            driveCycle();
        end while (doneCount == startDone);
        // either back to back or a short gap
        if ($urandom_range(0, 1) == 1) begin
            dataEn <= 1'b0;
            repeat ($urandom_range(1, 4)) driveCycle();
        end
    endtask

    task automatic randomRequest();
        int   lenBytes;
        int   offset;
        len_t len;
        case ($urandom_range(0, 2))
            0: begin
                len      = 3'd1;
                lenBytes = 1;
            end
            1: begin
                len      = 3'd2;
                lenBytes = 2;
            end
            default: begin
                len      = 3'd4;
                lenBytes = 4;
            end
        endcase
        offset = $urandom_range(0, windowBytes / lenBytes - 1) * lenBytes;
        issueRequest($urandom_range(0, 1) == 1, len, addr_t'(offset), $urandom());
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            stopRun($sformatf("timeout, run not finished after %0d cycles", timeoutCycles));
        end
    end

    initial begin
        rst          <= 1'b1;
        rdy          <= 1'b1;
        ioBufferFull <= 1'b0;
        redirect     <= 1'b0;
        redirectPc   <= '0;
        dataEn       <= 1'b0;
        dataReq      <= '0;
        void'($urandom(32'hb4176316));
        for (int i = 0; i < ramBytes; i++) begin
            modelMem[i] = '0;
        end
        modelPc    = resetPc;
        pendValid  = 1'b0;
        pendPc     = '0;
        prevOwner  = ownIdle;
        prevDone   = 1'b0;
        issueCount = 0;
        doneCount  = 0;
        fetchCount = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // first cycle out of reset, fetch is not running yet
        @(negedge clk);
        checkOwner("ownerAfterReset", ownIdle, owner);
        if (dataDone || fetchValid) begin
            stopRun("done pulse in the first cycle after reset");
        end
        @(posedge clk);
        for (int op = 0; op < numOps; op++) begin
            randomRequest();
        end
        // word reads over the whole window
        for (int a = 0; a < windowBytes; a += 4) begin
            issueRequest(1'b0, 3'd4, addr_t'(a), '0);
        end
        dataEn <= 1'b0;
        repeat (20) driveCycle();
        if (doneCount != issueCount) begin
            stopRun($sformatf("%0d data requests but %0d dataDone pulses",
                              issueCount, doneCount));
        end else if (fetchCount == 0) begin
            stopRun("no instruction fetch completed");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
rtl/memPkg.sv
rtl/fetchPort.sv
rtl/memCtrl.sv
rtl/byteRam.sv
rtl/memSubsystem.sv
verification/memSubsystemTb.sv

// File: Makefile
TOP := memSubsystemTb
OBJ := obj_dir

SOURCES := tb.f include/tbTypes.svh $(wildcard rtl/*.sv) $(wildcard verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): $(SOURCES)
	verilator --binary --assert -f tb.f --top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)

# exit status of the simulation is the result
run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
